// ==== build.f ====
src/fetch_pkg.sv
src/fetch_req_fsm.sv
src/fetch_addr_cnt.sv
src/fetch_fifo.sv
src/pc_target_mux.sv
src/if_id_regs.sv
src/if_stage.sv
dv/tb_if_stage.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the fetch stage testbench with Verilator and runs it
set -u
cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_if_stage -f build.f -o tb_if_stage
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_if_stage > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "All tests passed" "$log"; then
  exit 0
fi
exit 1

// ==== dv/tb_if_stage.sv ====
/*
 * Fetch stage testbench
 * random-latency memory model, ID-side scoreboard and directed tests
 */

`timescale 1ns/1ps

module tb_if_stage;

  localparam fetch_pkg::addr_t HaltAddr = 32'h0000_6800;
  localparam fetch_pkg::addr_t ExcAddr  = 32'h0000_6900;
  localparam fetch_pkg::addr_t DataKey  = 32'h5a5a_0ff0;
  // bus error window, upper bound exclusive
  localparam fetch_pkg::addr_t ErrLo    = 32'h0000_4000;
  localparam fetch_pkg::addr_t ErrHi    = 32'h0000_4010;
  localparam int               NumTests = 5;

  logic clk_i, rst_ni, req_i, id_in_ready_i, instr_valid_clear_i, pc_set_i;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i, instr_bus_err_i;
  logic instr_valid_id_o, instr_new_id_o, instr_fetch_err_o, csr_mtvec_init_o, if_busy_o;
  fetch_pkg::addr_t       boot_addr_i, branch_target_i, csr_mepc_i, csr_depc_i, csr_mtvec_i;
  fetch_pkg::addr_t       instr_addr_o, pc_if_o, pc_id_o;
  fetch_pkg::instr_t      instr_rdata_i, instr_rdata_id_o;
  fetch_pkg::pc_sel_e     pc_mux_i;
  fetch_pkg::exc_pc_sel_e exc_pc_mux_i;
  fetch_pkg::irq_id_t     irq_id_i;

  // memory model state
  logic             gnt_en, mem_pend, gnt_seen;
  fetch_pkg::addr_t mem_addr, gnt_addr;
  int               gnt_wait, rv_wait, rv_pick;
  // scoreboard state
  fetch_pkg::addr_t exp_pc, exp_next, hold_pc;
  fetch_pkg::instr_t hold_data;
  logic             hold_chk;
  int               n_words, n_err, err_cnt, tests_run;
  logic [31:0]      lcg_state = 32'h0a8b_0670;

  if_stage #(.DmHaltAddr(HaltAddr), .DmExceptionAddr(ExcAddr)) dut_i (.*);

  always #5 clk_i = ~clk_i;

  // grant only a live request
  assign instr_gnt_i = instr_req_o & gnt_en;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic in_err_window(input fetch_pkg::addr_t a);
    return (a >= ErrLo) && (a < ErrHi);
  endfunction

  // expected redirect target, built from the vector rules
  function automatic fetch_pkg::addr_t target_of(input fetch_pkg::pc_sel_e sel,
      input fetch_pkg::exc_pc_sel_e esel, input fetch_pkg::irq_id_t id);
    fetch_pkg::addr_t base;
    base = {csr_mtvec_i[31:8], 8'h00};
    case (sel)
      fetch_pkg::PC_BOOT: return {boot_addr_i[31:8], 8'h80};
      fetch_pkg::PC_JUMP: return branch_target_i;
      fetch_pkg::PC_ERET: return csr_mepc_i;
      fetch_pkg::PC_DRET: return csr_depc_i;
      default: begin
        case (esel)
          // slots 4 bytes apart above the mtvec base
          fetch_pkg::EXC_PC_IRQ:     return base + 32'(id) * 32'd4;
          fetch_pkg::EXC_PC_DBD:     return HaltAddr;
          fetch_pkg::EXC_PC_DBG_EXC: return ExcAddr;
          default:                   return base;
        endcase
      end
    endcase
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  ////////////////////
  // memory model
  ////////////////////

  // handshake seen at the clock edge
  always @(posedge clk_i) begin
    gnt_seen = instr_req_o && instr_gnt_i;
    if (gnt_seen) begin
      gnt_addr = instr_addr_o;
      rv_pick  = 1 + int'((next_rand() >> 16) % 32'd3);
      gnt_wait = int'((next_rand() >> 16) % 32'd4);
    end else if (instr_req_o && gnt_wait > 0) begin
      gnt_wait--;
    end
  end

  // response side, driven on the falling edge
  always @(negedge clk_i) begin
    gnt_en         = (gnt_wait == 0);
    instr_rvalid_i = 1'b0;
    if (gnt_seen) begin
      mem_pend = 1'b1;
      mem_addr = gnt_addr;
      rv_wait  = rv_pick;
    end
    if (mem_pend) begin
      rv_wait--;
      if (rv_wait == 0) begin
        instr_rvalid_i  = 1'b1;
        instr_rdata_i   = mem_addr ^ DataKey;
        instr_bus_err_i = in_err_window(mem_addr);
        mem_pend        = 1'b0;
      end
    end
  end

  ////////////////////
  // ID-side scoreboard
  ////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      // outputs frozen after a stalled cycle
      if (hold_chk) begin
        compare_word("pc_id_o", pc_id_o, hold_pc);
        compare_word("instr_rdata_id_o", instr_rdata_id_o, hold_data);
        compare_word("instr_new_id_o", 32'(instr_new_id_o), 32'd0);
      end
      hold_chk  = !id_in_ready_i && instr_valid_id_o;
      hold_pc   = pc_id_o;
      hold_data = instr_rdata_id_o;
      // every registered word must be the next one of the stream
      if (instr_new_id_o) begin
        compare_word("pc_id_o", pc_id_o, exp_pc);
        compare_word("instr_rdata_id_o", instr_rdata_id_o, exp_pc ^ DataKey);
        compare_word("instr_fetch_err_o", 32'(instr_fetch_err_o),
                     32'(in_err_window(exp_pc)));
        n_words++;
        if (instr_fetch_err_o) begin
          n_err++;
        end
        exp_pc = exp_pc + 32'd4;
      end
      // FIFO head is the next word of the stream
      compare_word("pc_if_o", pc_if_o, exp_pc);
      if (pc_set_i) begin
        exp_pc = {exp_next[31:2], 2'b00};
      end
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  // called on a falling edge, returns on a falling edge
  task automatic issue_redirect(input fetch_pkg::pc_sel_e sel,
      input fetch_pkg::exc_pc_sel_e esel, input fetch_pkg::irq_id_t id);
    pc_mux_i     = sel;
    exc_pc_mux_i = esel;
    irq_id_i     = id;
    exp_next     = target_of(sel, esel, id);
    pc_set_i     = 1'b1;
    @(posedge clk_i);
    compare_word("csr_mtvec_init_o", 32'(csr_mtvec_init_o),
                 32'(sel == fetch_pkg::PC_BOOT));
    @(negedge clk_i);
    pc_set_i = 1'b0;
  endtask

  task automatic wait_words(input int n);
    int goal;
    int cycles;
    goal   = n_words + n;
    cycles = 0;
    while (n_words < goal && cycles < 40 * n) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (n_words >= goal) else begin
      $display("fetch stalled at %0t, %0d of %0d words arrived", $time, n_words - goal + n, n);
      err_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    $display("%s finished with %0d errors", name, err_cnt - errs_before);
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic boot_fetch();
    int e0;
    e0 = err_cnt;
    // idle until the first redirect
    repeat (3) begin
      @(negedge clk_i);
      compare_word("instr_req_o", 32'(instr_req_o), 32'd0);
      compare_word("if_busy_o", 32'(if_busy_o), 32'd0);
      compare_word("instr_valid_id_o", 32'(instr_valid_id_o), 32'd0);
    end
    issue_redirect(fetch_pkg::PC_BOOT, fetch_pkg::EXC_PC_EXC, 5'd0);
    wait_words(6);
    report_test("boot fetch", e0);
  endtask

  task automatic jump_redirect();
    int e0;
    int k;
    e0 = err_cnt;
    for (int i = 0; i < 3; i++) begin
      // catch the engine with a request in flight
      k = 0;
      while (!if_busy_o && k < 20) begin
        @(negedge clk_i);
        k++;
      end
      branch_target_i = 32'h0000_3001 + 32'(i) * 32'h102;
      issue_redirect(fetch_pkg::PC_JUMP, fetch_pkg::EXC_PC_EXC, 5'd0);
      wait_words(3);
    end
    report_test("jump redirect", e0);
  endtask

  task automatic exc_vectors();
    int e0;
    fetch_pkg::irq_id_t ids [3];
    e0  = err_cnt;
    ids = '{5'd3, 5'd17, 5'd31};
    issue_redirect(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_EXC, 5'd0);
    wait_words(2);
    foreach (ids[i]) begin
      issue_redirect(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_IRQ, ids[i]);
      wait_words(2);
    end
    issue_redirect(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_DBD, 5'd0);
    wait_words(2);
    issue_redirect(fetch_pkg::PC_EXC, fetch_pkg::EXC_PC_DBG_EXC, 5'd0);
    wait_words(2);
    issue_redirect(fetch_pkg::PC_ERET, fetch_pkg::EXC_PC_EXC, 5'd0);
    wait_words(2);
    issue_redirect(fetch_pkg::PC_DRET, fetch_pkg::EXC_PC_EXC, 5'd0);
    wait_words(2);
    report_test("exception vectors", e0);
  endtask

  task automatic id_backpressure();
    int e0;
    int span;
    logic [31:0] r;
    e0 = err_cnt;
    for (int i = 0; i < 10; i++) begin
      r             = next_rand();
      id_in_ready_i = r[20];
      span          = 1 + int'((r >> 24) % 32'd5);
      repeat (span) @(negedge clk_i);
    end
    id_in_ready_i = 1'b1;
    wait_words(4);
    // stall long enough to fill the FIFO, then drop the ID word
    id_in_ready_i = 1'b0;
    repeat (8) @(negedge clk_i);
    instr_valid_clear_i = 1'b1;
    @(negedge clk_i);
    instr_valid_clear_i = 1'b0;
    compare_word("instr_valid_id_o", 32'(instr_valid_id_o), 32'd0);
    id_in_ready_i = 1'b1;
    wait_words(4);
    report_test("ID back-pressure", e0);
  endtask

  task automatic bus_error_window();
    int e0;
    int err0;
    e0   = err_cnt;
    err0 = n_err;
    // two clean words, four in the window, two clean again
    branch_target_i = ErrLo - 32'd6;
    issue_redirect(fetch_pkg::PC_JUMP, fetch_pkg::EXC_PC_EXC, 5'd0);
    wait_words(8);
    compare_word("errored word count", 32'(n_err - err0), 32'd4);
    report_test("bus error", e0);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    clk_i = 1'b0;
    rst_ni = 1'b0;
    req_i = 1'b1;
    id_in_ready_i = 1'b1;
    instr_valid_clear_i = 1'b0;
    pc_set_i = 1'b0;
    pc_mux_i = fetch_pkg::PC_BOOT;
    exc_pc_mux_i = fetch_pkg::EXC_PC_EXC;
    irq_id_i = 5'd0;
    boot_addr_i = 32'h0000_2345;
    branch_target_i = '0;
    csr_mepc_i = 32'h0000_5556;
    csr_depc_i = 32'h0000_7010;
    csr_mtvec_i = 32'h0000_8a01;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    instr_bus_err_i = 1'b0;
    gnt_en = 1'b0;
    gnt_seen = 1'b0;
    mem_pend = 1'b0;
    gnt_wait = 0;
    rv_wait = 0;
    exp_pc = '0;
    exp_next = '0;
    hold_chk = 1'b0;
    n_words = 0;
    n_err = 0;
    err_cnt = 0;
    tests_run = 0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    boot_fetch();
    jump_redirect();
    exc_vectors();
    id_backpressure();
    bus_error_window();
    $display("%0d tests run, %0d checks failed", tests_run, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // bound on the whole run
  initial begin
    repeat (NumTests * 200 + 5) @(posedge clk_i);
    $display("watchdog expired before the tests completed");
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== src/if_stage.sv ====
/*
 * Instruction fetch stage
 * next-PC selection, word fetch over req/gnt/rvalid, fetch FIFO and IF-ID registers
 */

`timescale 1ns/1ps

module if_stage #(
  parameter fetch_pkg::addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter fetch_pkg::addr_t DmExceptionAddr = 32'h1A11_0900
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  fetch_pkg::addr_t       boot_addr_i,
  input  logic                   req_i,
  // instruction memory port
  output logic                   instr_req_o,
  output fetch_pkg::addr_t       instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  fetch_pkg::instr_t      instr_rdata_i,
  input  logic                   instr_bus_err_i,
  // towards ID
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,
  output fetch_pkg::instr_t      instr_rdata_id_o,
  output logic                   instr_fetch_err_o,
  output fetch_pkg::addr_t       pc_if_o,
  output fetch_pkg::addr_t       pc_id_o,
  // control from ID
  input  logic                   instr_valid_clear_i,
  input  logic                   pc_set_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::irq_id_t     irq_id_i,
  input  fetch_pkg::addr_t       branch_target_i,
  // CSRs
  input  fetch_pkg::addr_t       csr_mepc_i,
  input  fetch_pkg::addr_t       csr_depc_i,
  input  fetch_pkg::addr_t       csr_mtvec_i,
  output logic                   csr_mtvec_init_o,
  input  logic                   id_in_ready_i,
  output logic                   if_busy_o
);

  fetch_pkg::addr_t  fetch_target;
  logic              fifo_push;
  logic [1:0]        fifo_cnt;
  logic              fetch_valid;
  fetch_pkg::instr_t fetch_rdata;
  logic              fetch_err;
  fetch_pkg::addr_t  fetch_addr;
  logic              fetch_accept;

  pc_target_mux #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) pc_target_mux_i (
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_id_i         (irq_id_i),
    .pc_set_i         (pc_set_i),
    .target_o         (fetch_target),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  fetch_req_fsm fetch_req_fsm_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .fifo_cnt_i     (fifo_cnt),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_req_o    (instr_req_o),
    .fifo_push_o    (fifo_push),
    .busy_o         (if_busy_o)
  );

  // memory grants only a live request, so gnt alone steps the address
  fetch_addr_cnt fetch_addr_cnt_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .load_i   (pc_set_i),
    .target_i (fetch_target),
    .step_i   (instr_gnt_i),
    .addr_o   (instr_addr_o)
  );

  fetch_fifo fetch_fifo_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .flush_i  (pc_set_i),
    .target_i (fetch_target),
    .push_i   (fifo_push),
    .rdata_i  (instr_rdata_i),
    .err_i    (instr_bus_err_i),
    .pop_i    (fetch_accept),
    .cnt_o    (fifo_cnt),
    .valid_o  (fetch_valid),
    .rdata_o  (fetch_rdata),
    .err_o    (fetch_err),
    .addr_o   (fetch_addr)
  );

  if_id_regs if_id_regs_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_err_i         (fetch_err),
    .fetch_addr_i        (fetch_addr),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .accept_o            (fetch_accept),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o)
  );

  // PC of the word at the FIFO head
  assign pc_if_o = fetch_addr;

endmodule

// ==== src/if_id_regs.sv ====
/*
 * IF-ID pipeline registers
 * valid and new flags plus the instruction word, bus error and PC for ID
 */

`timescale 1ns/1ps

module if_id_regs (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              fetch_valid_i,
  input  fetch_pkg::instr_t fetch_rdata_i,
  input  logic              fetch_err_i,
  input  fetch_pkg::addr_t  fetch_addr_i,
  input  logic              id_in_ready_i,
  input  logic              pc_set_i,
  input  logic              instr_valid_clear_i,
  output logic              accept_o,
  output logic              instr_valid_id_o,
  output logic              instr_new_id_o,
  output fetch_pkg::instr_t instr_rdata_id_o,
  output logic              instr_fetch_err_o,
  output fetch_pkg::addr_t  pc_id_o
);

  logic valid_q;
  logic new_q;

  // a redirect squashes the word on offer
  assign accept_o = fetch_valid_i & id_in_ready_i & ~pc_set_i;

  ////////////////////
  // flags
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q           <= 1'b0;
      new_q             <= 1'b0;
      instr_fetch_err_o <= 1'b0;
    end else begin
      // valid holds until ID clears it
      valid_q <= accept_o | (valid_q & ~instr_valid_clear_i);
      new_q   <= accept_o;
      if (accept_o) begin
        instr_fetch_err_o <= fetch_err_i;
      end
    end
  end

  // word and PC frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (accept_o) begin
      instr_rdata_id_o <= fetch_rdata_i;
      pc_id_o          <= fetch_addr_i;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

// ==== src/pc_target_mux.sv ====
/*
 * Next-PC selection
 * exception vector computation, fetch target mux and mtvec init on boot
 */

`timescale 1ns/1ps

module pc_target_mux #(
  parameter fetch_pkg::addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter fetch_pkg::addr_t DmExceptionAddr = 32'h1A11_0900
) (
  input  fetch_pkg::addr_t       boot_addr_i,
  input  fetch_pkg::addr_t       branch_target_i,
  input  fetch_pkg::addr_t       csr_mepc_i,
  input  fetch_pkg::addr_t       csr_depc_i,
  input  fetch_pkg::addr_t       csr_mtvec_i,
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::irq_id_t     irq_id_i,
  input  logic                   pc_set_i,
  output fetch_pkg::addr_t       target_o,
  output logic                   csr_mtvec_init_o
);

  fetch_pkg::addr_t exc_pc;

  // mtvec base is 256-byte aligned, irq slots are 4 bytes apart
  always_comb begin
    unique case (exc_pc_mux_i)
      fetch_pkg::EXC_PC_EXC:     exc_pc = {csr_mtvec_i[31:8], 8'h00};
      fetch_pkg::EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[31:8], 1'b0, irq_id_i, 2'b00};
      fetch_pkg::EXC_PC_DBD:     exc_pc = DmHaltAddr;
      fetch_pkg::EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:                   exc_pc = {csr_mtvec_i[31:8], 8'h00};
    endcase
  end

  // fetch target
  always_comb begin
    unique case (pc_mux_i)
      fetch_pkg::PC_BOOT: target_o = {boot_addr_i[31:8], fetch_pkg::BootOffset};
      fetch_pkg::PC_JUMP: target_o = branch_target_i;
      fetch_pkg::PC_EXC:  target_o = exc_pc;
      // return from trap
      fetch_pkg::PC_ERET: target_o = csr_mepc_i;
      // return from debug mode
      fetch_pkg::PC_DRET: target_o = csr_depc_i;
      default:            target_o = {boot_addr_i[31:8], fetch_pkg::BootOffset};
    endcase
  end

  // CSR file sets mtvec from boot_addr on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == fetch_pkg::PC_BOOT);

endmodule

// ==== src/fetch_fifo.sv ====
/*
 * Fetch FIFO
 * holds fetched words with their bus error bits and tracks the PC of the oldest
 */

`timescale 1ns/1ps

module fetch_fifo (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              flush_i,
  input  fetch_pkg::addr_t  target_i,
  input  logic              push_i,
  input  fetch_pkg::instr_t rdata_i,
  input  logic              err_i,
  input  logic              pop_i,
  output logic [1:0]        cnt_o,
  output logic              valid_o,
  output fetch_pkg::instr_t rdata_o,
  output logic              err_o,
  output fetch_pkg::addr_t  addr_o
);

  localparam int unsigned IdxW = $clog2(fetch_pkg::FetchFifoDepth);

  fetch_pkg::instr_t data_q [fetch_pkg::FetchFifoDepth];
  logic              err_q  [fetch_pkg::FetchFifoDepth];
  logic [1:0]        cnt_q;
  logic [1:0]        wr_slot;
  logic [IdxW-1:0]   wr_idx;
  fetch_pkg::addr_t  addr_q;

  // entry 0 is the oldest, a pop shifts the rest down
  assign wr_slot = pop_i ? (cnt_q - 2'd1) : cnt_q;
  assign wr_idx  = wr_slot[IdxW-1:0];

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (pop_i) begin
      for (int i = 0; i < fetch_pkg::FetchFifoDepth - 1; i++) begin
        data_q[i] <= data_q[i+1];
        err_q[i]  <= err_q[i+1];
      end
    end
    // write lands after the shift
    if (push_i && !flush_i) begin
      data_q[wr_idx] <= rdata_i;
      err_q[wr_idx]  <= err_i;
    end
  end

  // count and PC of the head entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q  <= 2'd0;
      addr_q <= '0;
    end else if (flush_i) begin
      cnt_q  <= 2'd0;
      addr_q <= {target_i[31:2], 2'b00};
    end else begin
      cnt_q <= cnt_q + {1'b0, push_i} - {1'b0, pop_i};
      if (pop_i) begin
        addr_q <= addr_q + fetch_pkg::addr_t'(fetch_pkg::WordBytes);
      end
    end
  end

  assign cnt_o   = cnt_q;
  assign valid_o = (cnt_q != 2'd0);
  assign rdata_o = data_q[0];
  assign err_o   = err_q[0];
  assign addr_o  = addr_q;

endmodule

// ==== src/fetch_addr_cnt.sv ====
/*
 * Fetch address counter
 * next word request address, loaded on redirect and stepped on grant
 */

`timescale 1ns/1ps

module fetch_addr_cnt (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             load_i,
  input  fetch_pkg::addr_t target_i,
  input  logic             step_i,
  output fetch_pkg::addr_t addr_o
);

  fetch_pkg::addr_t addr_q;
  fetch_pkg::addr_t addr_d;

  // redirect wins over a grant in the same cycle
  always_comb begin
    addr_d = addr_q;
    if (load_i) begin
      // word fetch only, drop the byte offset
      addr_d = {target_i[31:2], 2'b00};
    end else if (step_i) begin
      addr_d = addr_q + fetch_pkg::addr_t'(fetch_pkg::WordBytes);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else begin
      addr_q <= addr_d;
    end
  end

  assign addr_o = addr_q;

endmodule

// ==== src/fetch_req_fsm.sv ====
/*
 * Fetch request engine
 * issues one word request at a time over req/gnt/rvalid and flags stale responses
 */

`timescale 1ns/1ps

module fetch_req_fsm (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_i,
  input  logic       pc_set_i,
  input  logic [1:0] fifo_cnt_i,
  input  logic       instr_gnt_i,
  input  logic       instr_rvalid_i,
  output logic       instr_req_o,
  output logic       fifo_push_o,
  output logic       busy_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_GNT,
    WAIT_RVALID
  } req_state_e;

  req_state_e state_q, state_d;
  logic       discard_q, discard_d;
  logic       started_q;
  logic       room;
  logic       start_req;

  // only one request in flight, so in IDLE the FIFO count alone decides room
  assign room = int'(fifo_cnt_i) < fetch_pkg::FetchFifoDepth;

  // new request from IDLE, never in the redirect cycle itself
  assign start_req = (state_q == IDLE) & req_i & started_q & room & ~pc_set_i;

  // request held until the grant arrives
  assign instr_req_o = start_req | (state_q == WAIT_GNT);

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start_req) begin
          state_d = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
        end
      end
      WAIT_GNT: begin
        if (instr_gnt_i) begin
          state_d = WAIT_RVALID;
        end
      end
      WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // a redirect makes the granted or in-flight response stale
  always_comb begin
    discard_d = discard_q;
    if (instr_rvalid_i) begin
      discard_d = 1'b0;
    end else if (pc_set_i && ((state_q == WAIT_RVALID) || (instr_req_o && instr_gnt_i))) begin
      discard_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      discard_q <= 1'b0;
      started_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      discard_q <= discard_d;
      // fetching begins with the first redirect
      if (pc_set_i) begin
        started_q <= 1'b1;
      end
    end
  end

  // keep the word unless stale or hit by a redirect this cycle
  assign fifo_push_o = instr_rvalid_i & ~discard_q & ~pc_set_i;
  assign busy_o      = (state_q != IDLE);

endmodule

// ==== src/fetch_pkg.sv ====
/*
 * Fetch stage package
 * address and instruction types, PC selector encodings and fixed constants
 */

package fetch_pkg;

  // byte address and fetched instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;

  // interrupt line number, picks the vectored slot under mtvec
  typedef logic [4:0] irq_id_t;

  // next-PC source
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // exception PC source
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

  // low byte of the boot PC, below boot_addr[31:8]
  parameter logic [7:0] BootOffset = 8'h80;

  // fetch FIFO entries and the word step
  parameter int unsigned FetchFifoDepth = 2;
  parameter int unsigned WordBytes      = 4;

endpackage
